// ==== cpuDecode.f ====
design/dekodierPkg.sv
design/registerBank.sv
design/instruktionsDekodierer.sv
design/operandAuswahl.sv
design/dekodierStufe.sv
tests/dekodierStufeTb.sv

// ==== design/dekodierPkg.sv ====
`default_nettype none

package dekodierPkg;

    localparam int wortBreite   = 32;
    localparam int regAdrBreite = 6;   // Bit 5 selects the float half
    localparam int immBreite    = 26;
    localparam int regAnzahl    = 2 ** regAdrBreite;

    // Top two bits of a word that does not start with 1
    localparam logic [1:0] klasseRegister = 2'b00;
    localparam logic [1:0] klasseGrossImm = 2'b01;

    localparam logic [5:0] opAbsSprung      = 6'b101101;
    localparam logic [5:0] opBedSprung      = 6'b101110;
    localparam logic [5:0] opJal            = 6'b101111;
    localparam logic [5:0] opRelSprungGross = 6'b010000;
    localparam logic [5:0] opStore          = 6'b101100;
    localparam logic [5:0] opFloatLoad      = 6'b101011;
    localparam logic [4:0] loadPraefix      = 5'b10101;

    // Bit positions inside opFlags, flagImm is set for either immediate format
    localparam int opFlagBreite = 9;
    localparam int flagImm      = 8;
    localparam int flagJal      = 7;
    localparam int flagRel      = 6;
    localparam int flagAbs      = 5;
    localparam int flagFloat    = 4;
    localparam int flagLoad     = 3;
    localparam int flagStore    = 2;
    localparam int flagUnbed    = 1;
    localparam int flagBed      = 0;

    // Register numbers sit at the same bit positions in both layouts
    typedef union packed {
        struct packed {
            logic [1:0] klasse;
            logic [3:0] frei;
            logic [4:0] ziel;
            logic [4:0] quelle1;
            logic [4:0] quelle2;
            logic [4:0] unbenutzt;
            logic [5:0] funktion;
        } regSicht;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  ziel;
            logic [4:0]  quelle1;
            logic [15:0] imm16;
        } immSicht;
    } befehlWort;

endpackage

`default_nettype wire

// ==== design/dekodierStufe.sv ====
`timescale 1ns/1ns
`default_nettype none

module dekodierStufe import dekodierPkg::*; (
    input  wire logic                    DekodierSignal,
    input  wire logic                    rstN,
    input  wire befehlWort               befehl,
    input  wire logic                    befehlValid,
    output logic                         befehlReady,
    input  wire logic                    schreibEnable,
    input  wire logic [regAdrBreite-1:0] schreibAdresse,
    input  wire logic [wortBreite-1:0]   schreibDaten,
    output logic                         opValid,
    input  wire logic                    opReady,
    output logic [wortBreite-1:0]        operandA,
    output logic [wortBreite-1:0]        operandB,
    output logic [wortBreite-1:0]        storeDaten,
    output logic [regAdrBreite-1:0]      opZiel,
    output logic [5:0]                   opFunktion,
    output logic [opFlagBreite-1:0]      opFlags
);

    logic                    decValid;
    logic                    decReady;
    logic [regAdrBreite-1:0] quellRegister1;
    logic [regAdrBreite-1:0] quellRegister2;
    logic [regAdrBreite-1:0] zielRegister;
    logic [immBreite-1:0]    iDaten;
    logic                    kleinerImmediateAktiv;
    logic                    grosserImmediateAktiv;
    logic [5:0]              funktionsCode;
    logic                    jalBefehl;
    logic                    relativerSprung;
    logic                    absoluterSprung;
    logic                    floatBefehl;
    logic                    loadBefehl;
    logic                    storeBefehl;
    logic                    unbedingterSprungBefehl;
    logic                    bedingterSprungBefehl;
    logic [wortBreite-1:0]   leseDaten1;
    logic [wortBreite-1:0]   leseDaten2;

    instruktionsDekodierer dekodierer (
        .DekodierSignal          (DekodierSignal),
        .rstN                    (rstN),
        .befehl                  (befehl),
        .befehlValid             (befehlValid),
        .decReady                (decReady),
        .befehlReady             (befehlReady),
        .decValid                (decValid),
        .quellRegister1          (quellRegister1),
        .quellRegister2          (quellRegister2),
        .zielRegister            (zielRegister),
        .iDaten                  (iDaten),
        .kleinerImmediateAktiv   (kleinerImmediateAktiv),
        .grosserImmediateAktiv   (grosserImmediateAktiv),
        .funktionsCode           (funktionsCode),
        .jalBefehl               (jalBefehl),
        .relativerSprung         (relativerSprung),
        .absoluterSprung         (absoluterSprung),
        .floatBefehl             (floatBefehl),
        .loadBefehl              (loadBefehl),
        .storeBefehl             (storeBefehl),
        .unbedingterSprungBefehl (unbedingterSprungBefehl),
        .bedingterSprungBefehl   (bedingterSprungBefehl)
    );

    // Source numbers address the bank directly, data returns in the same cycle
    registerBank bank (
        .DekodierSignal (DekodierSignal),
        .rstN           (rstN),
        .leseAdresse1   (quellRegister1),
        .leseAdresse2   (quellRegister2),
        .schreibEnable  (schreibEnable),
        .schreibAdresse (schreibAdresse),
        .schreibDaten   (schreibDaten),
        .leseDaten1     (leseDaten1),
        .leseDaten2     (leseDaten2)
    );

    operandAuswahl auswahl (
        .DekodierSignal          (DekodierSignal),
        .rstN                    (rstN),
        .decValid                (decValid),
        .zielRegister            (zielRegister),
        .iDaten                  (iDaten),
        .kleinerImmediateAktiv   (kleinerImmediateAktiv),
        .grosserImmediateAktiv   (grosserImmediateAktiv),
        .funktionsCode           (funktionsCode),
        .jalBefehl               (jalBefehl),
        .relativerSprung         (relativerSprung),
        .absoluterSprung         (absoluterSprung),
        .floatBefehl             (floatBefehl),
        .loadBefehl              (loadBefehl),
        .storeBefehl             (storeBefehl),
        .unbedingterSprungBefehl (unbedingterSprungBefehl),
        .bedingterSprungBefehl   (bedingterSprungBefehl),
        .leseDaten1              (leseDaten1),
        .leseDaten2              (leseDaten2),
        .opReady                 (opReady),
        .decReady                (decReady),
        .opValid                 (opValid),
        .operandA                (operandA),
        .operandB                (operandB),
        .storeDaten              (storeDaten),
        .opZiel                  (opZiel),
        .opFunktion              (opFunktion),
        .opFlags                 (opFlags)
    );

endmodule

`default_nettype wire

// ==== design/instruktionsDekodierer.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruktionsDekodierer import dekodierPkg::*; (
    input  wire logic                    DekodierSignal,
    input  wire logic                    rstN,
    input  wire befehlWort               befehl,
    input  wire logic                    befehlValid,
    input  wire logic                    decReady,
    output logic                         befehlReady,
    output logic                         decValid,
    output logic [regAdrBreite-1:0]      quellRegister1,
    output logic [regAdrBreite-1:0]      quellRegister2,
    output logic [regAdrBreite-1:0]      zielRegister,
    output logic [immBreite-1:0]         iDaten,
    output logic                         kleinerImmediateAktiv,
    output logic                         grosserImmediateAktiv,
    output logic [5:0]                   funktionsCode,
    output logic                         jalBefehl,
    output logic                         relativerSprung,
    output logic                         absoluterSprung,
    output logic                         floatBefehl,
    output logic                         loadBefehl,
    output logic                         storeBefehl,
    output logic                         unbedingterSprungBefehl,
    output logic                         bedingterSprungBefehl
);

    befehlWort  aktuellerBefehl;
    logic       annahme;
    logic [5:0] opcode;
    logic       regFormat;
    logic       grossFormat;
    logic       kleinFormat;
    logic       floatRegister;
    logic       floatLoad;
    logic       relSprungGross;
    logic       ohneFunktion;

    assign befehlReady = !decValid || decReady;
    assign annahme     = befehlValid && befehlReady;

    always_ff @(posedge DekodierSignal) begin
        if (!rstN) begin
            aktuellerBefehl <= '0;   // Decodes as register format, all fields zero
            decValid        <= 1'b0;
        end else if (annahme) begin
            aktuellerBefehl <= befehl;
            decValid        <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    assign opcode        = aktuellerBefehl.immSicht.opcode;
    assign regFormat     = aktuellerBefehl.regSicht.klasse == klasseRegister;
    assign grossFormat   = aktuellerBefehl.regSicht.klasse == klasseGrossImm;
    assign kleinFormat   = opcode[5];
    assign floatRegister = regFormat && aktuellerBefehl.regSicht.funktion[5:4] == 2'b10;
    assign floatLoad     = opcode == opFloatLoad;
    assign relSprungGross = opcode == opRelSprungGross;

    // Loads, stores and jumps with a small immediate carry no function code
    assign ohneFunktion = opcode >= {loadPraefix, 1'b0} && opcode <= opJal;

    always_comb begin
        if (regFormat) begin
            quellRegister1 = {floatRegister, aktuellerBefehl.regSicht.quelle1};
        end else if (kleinFormat) begin
            quellRegister1 = {1'b0, aktuellerBefehl.immSicht.quelle1};
        end else begin
            quellRegister1 = '0;
        end
    end

    always_comb begin
        if (regFormat) begin
            quellRegister2 = {floatRegister, aktuellerBefehl.regSicht.quelle2};
        end else if (storeBefehl) begin
            quellRegister2 = {1'b0, aktuellerBefehl.immSicht.ziel};   // Store data register
        end else begin
            quellRegister2 = '0;
        end
    end

    always_comb begin
        if (regFormat) begin
            zielRegister = {floatRegister, aktuellerBefehl.regSicht.ziel};
        end else if (kleinFormat) begin
            zielRegister = {floatLoad, aktuellerBefehl.immSicht.ziel};
        end else begin
            zielRegister = '0;
        end
    end

    always_comb begin
        if (grossFormat) begin
            iDaten = {aktuellerBefehl.immSicht.ziel, aktuellerBefehl.immSicht.quelle1,
                      aktuellerBefehl.immSicht.imm16};
        end else if (kleinFormat) begin
            iDaten = {{(immBreite - 16){aktuellerBefehl.immSicht.imm16[15]}},
                      aktuellerBefehl.immSicht.imm16};
        end else begin
            iDaten = '0;
        end
    end

    always_comb begin
        if (regFormat) begin
            funktionsCode = aktuellerBefehl.regSicht.funktion;
        end else if (grossFormat || ohneFunktion) begin
            funktionsCode = '0;
        end else begin
            funktionsCode = {1'b0, opcode[4:0]};   // ALU op with small immediate
        end
    end

    assign kleinerImmediateAktiv   = kleinFormat;
    assign grosserImmediateAktiv   = grossFormat;
    assign jalBefehl               = opcode == opJal;
    assign relativerSprung         = jalBefehl || relSprungGross;
    assign absoluterSprung         = opcode == opAbsSprung;
    assign floatBefehl             = floatRegister || floatLoad;
    assign loadBefehl              = opcode[5:1] == loadPraefix;
    assign storeBefehl             = opcode == opStore;
    assign unbedingterSprungBefehl = absoluterSprung || jalBefehl || relSprungGross;
    assign bedingterSprungBefehl   = opcode == opBedSprung;

endmodule

`default_nettype wire

// ==== design/operandAuswahl.sv ====
`timescale 1ns/1ns
`default_nettype none

module operandAuswahl import dekodierPkg::*; (
    input  wire logic                    DekodierSignal,
    input  wire logic                    rstN,
    input  wire logic                    decValid,
    input  wire logic [regAdrBreite-1:0] zielRegister,
    input  wire logic [immBreite-1:0]    iDaten,
    input  wire logic                    kleinerImmediateAktiv,
    input  wire logic                    grosserImmediateAktiv,
    input  wire logic [5:0]              funktionsCode,
    input  wire logic                    jalBefehl,
    input  wire logic                    relativerSprung,
    input  wire logic                    absoluterSprung,
    input  wire logic                    floatBefehl,
    input  wire logic                    loadBefehl,
    input  wire logic                    storeBefehl,
    input  wire logic                    unbedingterSprungBefehl,
    input  wire logic                    bedingterSprungBefehl,
    input  wire logic [wortBreite-1:0]   leseDaten1,
    input  wire logic [wortBreite-1:0]   leseDaten2,
    input  wire logic                    opReady,
    output logic                         decReady,
    output logic                         opValid,
    output logic [wortBreite-1:0]        operandA,
    output logic [wortBreite-1:0]        operandB,
    output logic [wortBreite-1:0]        storeDaten,
    output logic [regAdrBreite-1:0]      opZiel,
    output logic [5:0]                   opFunktion,
    output logic [opFlagBreite-1:0]      opFlags
);

    logic                    uebernahme;
    logic                    immAktiv;
    logic [wortBreite-1:0]   immErweitert;
    logic [opFlagBreite-1:0] flags;

    assign decReady   = !opValid || opReady;
    assign uebernahme = decValid && decReady;

    assign immAktiv     = kleinerImmediateAktiv || grosserImmediateAktiv;
    assign immErweitert = {{(wortBreite - immBreite){iDaten[immBreite-1]}}, iDaten};

    always_comb begin
        flags            = '0;
        flags[flagImm]   = immAktiv;
        flags[flagJal]   = jalBefehl;
        flags[flagRel]   = relativerSprung;
        flags[flagAbs]   = absoluterSprung;
        flags[flagFloat] = floatBefehl;
        flags[flagLoad]  = loadBefehl;
        flags[flagStore] = storeBefehl;
        flags[flagUnbed] = unbedingterSprungBefehl;
        flags[flagBed]   = bedingterSprungBefehl;
    end

    always_ff @(posedge DekodierSignal) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else if (uebernahme) begin
            opValid <= 1'b1;
        end else if (opReady) begin
            opValid <= 1'b0;
        end
    end

    // Register data is sampled in the transfer cycle
    always_ff @(posedge DekodierSignal) begin
        if (uebernahme) begin
            operandA   <= leseDaten1;
            operandB   <= immAktiv ? immErweitert : leseDaten2;
            storeDaten <= leseDaten2;
            opZiel     <= zielRegister;
            opFunktion <= funktionsCode;
            opFlags    <= flags;
        end
    end

endmodule

`default_nettype wire

// ==== design/registerBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerBank import dekodierPkg::*; (
    input  wire logic                    DekodierSignal,
    input  wire logic                    rstN,
    input  wire logic [regAdrBreite-1:0] leseAdresse1,
    input  wire logic [regAdrBreite-1:0] leseAdresse2,
    input  wire logic                    schreibEnable,
    input  wire logic [regAdrBreite-1:0] schreibAdresse,
    input  wire logic [wortBreite-1:0]   schreibDaten,
    output logic [wortBreite-1:0]        leseDaten1,
    output logic [wortBreite-1:0]        leseDaten2
);

    logic [wortBreite-1:0] register [regAnzahl];

    // Integer register 0 is hardwired to zero
    always_ff @(posedge DekodierSignal) begin
        if (!rstN) begin
            for (int i = 0; i < regAnzahl; i++) begin
                register[i] <= '0;
            end
        end else if (schreibEnable && schreibAdresse != '0) begin
            register[schreibAdresse] <= schreibDaten;
        end
    end

    // A write in the same cycle is not forwarded, the old value is returned
    always_comb begin
        if (leseAdresse1 == '0) begin
            leseDaten1 = '0;
        end else begin
            leseDaten1 = register[leseAdresse1];
        end
    end

    always_comb begin
        if (leseAdresse2 == '0) begin
            leseDaten2 = '0;
        end else begin
            leseDaten2 = register[leseAdresse2];
        end
    end

endmodule

`default_nettype wire

// ==== tests/dekodierStufeTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dekodierStufeTb import dekodierPkg::*; ();

    logic                    DekodierSignal;
    logic                    rstN;
    befehlWort               befehl;
    logic                    befehlValid;
    logic                    befehlReady;
    logic                    schreibEnable;
    logic [regAdrBreite-1:0] schreibAdresse;
    logic [wortBreite-1:0]   schreibDaten;
    logic                    opValid;
    logic                    opReady;
    logic [wortBreite-1:0]   operandA;
    logic [wortBreite-1:0]   operandB;
    logic [wortBreite-1:0]   storeDaten;
    logic [regAdrBreite-1:0] opZiel;
    logic [5:0]              opFunktion;
    logic [opFlagBreite-1:0] opFlags;

    logic [31:0] trace [0:511];   // Up to 64 records of 8 columns each
    int          erwartet [$];
    int          anzahlRecords = 0;
    int          befehlAnzahl = 0;
    int          geprueft = 0;
    int          testsOk = 0;
    int          fehler = 0;
    int          zyklus = 0;
    bit          ersteAnnahme = 1'b0;
    bit          traceGeladen = 1'b0;
    integer      seed;
    logic [31:0] zufall;

    initial DekodierSignal = 1'b0;
    always #20 DekodierSignal = ~DekodierSignal;

    dekodierStufe DUT (
        .DekodierSignal (DekodierSignal),
        .rstN           (rstN),
        .befehl         (befehl),
        .befehlValid    (befehlValid),
        .befehlReady    (befehlReady),
        .schreibEnable  (schreibEnable),
        .schreibAdresse (schreibAdresse),
        .schreibDaten   (schreibDaten),
        .opValid        (opValid),
        .opReady        (opReady),
        .operandA       (operandA),
        .operandB       (operandB),
        .storeDaten     (storeDaten),
        .opZiel         (opZiel),
        .opFunktion     (opFunktion),
        .opFlags        (opFlags)
    );

    task automatic meldeFehler(input int nummer, input string feld,
                               input logic [31:0] ist, input logic [31:0] soll);
        fehler++;
        $display("ERR %0t: test %0d %s is %h, expected %h", $time, nummer, feld, ist, soll);
    endtask

    task automatic pruefeAusgang(input int idx);
        int        basis;
        int        fehlerVorher;
        befehlWort wort;
        basis = idx * 8;
        fehlerVorher = fehler;
        wort = trace[basis + 1];
        geprueft++;
        if (operandA !== trace[basis + 2])
            meldeFehler(geprueft, "operandA", operandA, trace[basis + 2]);
        if (operandB !== trace[basis + 3])
            meldeFehler(geprueft, "operandB", operandB, trace[basis + 3]);
        if (storeDaten !== trace[basis + 4])
            meldeFehler(geprueft, "storeDaten", storeDaten, trace[basis + 4]);
        if ({26'd0, opZiel} !== trace[basis + 5])
            meldeFehler(geprueft, "opZiel", {26'd0, opZiel}, trace[basis + 5]);
        if ({26'd0, opFunktion} !== trace[basis + 6])
            meldeFehler(geprueft, "opFunktion", {26'd0, opFunktion}, trace[basis + 6]);
        if ({23'd0, opFlags} !== trace[basis + 7])
            meldeFehler(geprueft, "opFlags", {23'd0, opFlags}, trace[basis + 7]);
        if (fehler == fehlerVorher)
            testsOk++;
        $display("test %0d word %h opcode %b: %s", geprueft, wort, wort.immSicht.opcode,
                 (fehler == fehlerVorher) ? "ok" : "mismatch");
    endtask

    task automatic warteBisLeer();
        while (erwartet.size() != 0) begin
            @(posedge DekodierSignal);
            #2;
        end
    endtask

    task automatic schreibeRegister(input logic [5:0] adresse, input logic [31:0] daten);
        schreibEnable  = 1'b1;
        schreibAdresse = adresse;
        schreibDaten   = daten;
        @(posedge DekodierSignal);
        #2;
        schreibEnable = 1'b0;
    endtask

    task automatic sendeBefehl(input int idx);
        befehl      = trace[idx * 8 + 1];
        befehlValid = 1'b1;
        @(posedge DekodierSignal);
        while (befehlReady !== 1'b1) @(posedge DekodierSignal);
        erwartet.push_back(idx);   // Accepted on this edge
        ersteAnnahme = 1'b1;
        #2;
        befehlValid = 1'b0;
    endtask

    // Outputs are registered, so the values seen at the edge are the ones being transferred
    always @(posedge DekodierSignal) begin
        zyklus++;
        if (zyklus > 1 && !ersteAnnahme && opValid !== 1'b0) begin
            fehler++;
            $display("ERR %0t: opValid is %b before any instruction was accepted", $time, opValid);
        end
        if (rstN && opValid && opReady) begin
            if (erwartet.size() == 0) begin
                fehler++;
                $display("An output transfer at %0t had no instruction outstanding", $time);
            end else begin
                pruefeAusgang(erwartet.pop_front());
            end
        end
    end

    always @(posedge DekodierSignal) begin
        #2;
        if (zyklus > 8) begin   // Back-pressure starts once reset is over
            zufall  = $random(seed);
            opReady = zufall[1:0] != 2'b00;
        end
    end

    // The decoder takes a word unless it is full and the operand stage stalls
    always @(negedge DekodierSignal) begin
        if (rstN && befehlReady !== (!opValid || opReady || erwartet.size() < 2)) begin
            fehler++;
            $display("ERR %0t: befehlReady is %b with %0d instructions in flight", $time,
                     befehlReady, erwartet.size());
        end
    end

    initial begin
        int i;
        int basis;
        seed           = 32'h617b;
        rstN           = 1'b0;
        befehl         = '0;
        befehlValid    = 1'b0;
        schreibEnable  = 1'b0;
        schreibAdresse = '0;
        schreibDaten   = '0;
        opReady        = 1'b0;
        $readmemh("tests/dekodierTrace.txt", trace);
        while (anzahlRecords < 64 && (trace[anzahlRecords * 8] === 32'h1 ||
                                      trace[anzahlRecords * 8] === 32'hB)) begin
            if (trace[anzahlRecords * 8] === 32'hB)
                befehlAnzahl++;
            anzahlRecords++;
        end
        traceGeladen = 1'b1;
        repeat (8) @(posedge DekodierSignal);
        #2;
        rstN = 1'b1;
        for (i = 0; i < anzahlRecords; i++) begin
            basis = i * 8;
            if (trace[basis] === 32'h1) begin
                warteBisLeer();   // Register writes only with the pipeline empty
                schreibeRegister(trace[basis + 1][5:0], trace[basis + 2]);
            end else begin
                sendeBefehl(i);
            end
        end
        warteBisLeer();
        repeat (4) @(posedge DekodierSignal);
        if (befehlAnzahl == 0)
            $display("The trace file held no instruction records");
        if (geprueft != befehlAnzahl)
            $display("Only %0d of %0d instructions left the stage", geprueft, befehlAnzahl);
        $display("%0d of %0d tests passed, %0d checked, %0d errors",
                 testsOk, befehlAnzahl, geprueft, fehler);
        if (fehler == 0 && geprueft == befehlAnzahl && befehlAnzahl > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Twenty cycles per record plus the reset phase
    initial begin
        wait (traceGeladen);
        #((anzahlRecords * 20 + 8) * 40);
        $display("The run timed out at %0t with %0d instructions still outstanding",
                 $time, erwartet.size());
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/dekodierTrace.txt ====
// kind  wort/adresse  operandA/daten  operandB  storeDaten  opZiel  opFunktion  opFlags
// Kind 1 writes daten to register adresse, kind B sends wort and expects the other columns
1 00000001 00000011 00000000 00000000 00 00 000
1 00000002 00000022 00000000 00000000 00 00 000
1 00000003 80000003 00000000 00000000 00 00 000
1 00000005 12345678 00000000 00000000 00 00 000
1 00000007 00000777 00000000 00000000 00 00 000
1 00000021 3F800000 00000000 00000000 00 00 000
1 00000022 40000000 00000000 00000000 00 00 000
1 00000000 DEADBEEF 00000000 00000000 00 00 000
B 00811005 00000011 00000022 00000022 04 05 000
B 00611021 3F800000 40000000 40000000 23 21 010
B 00C51FFA 12345678 80000003 80000003 06 3A 000
B A9010010 00000011 00000010 00000000 08 00 108
B A925FFF0 12345678 FFFFFFF0 00000000 09 00 108
B AC820004 00000022 00000004 00000000 24 00 118
B B0E1FFFC 00000011 FFFFFFFC 00000777 07 00 104
B 8D437FFF 80000003 00007FFF 00000000 0A 03 100
B 85628000 00000022 FFFF8000 00000000 0B 01 100
B 42000040 00000000 FE000040 00000000 00 00 142
B 7C123456 00000000 00123456 00000000 00 00 100
B BFE00100 00000000 00000100 00000000 1F 00 1C2
B B4050000 12345678 00000000 00000000 00 00 122
B B841FFF8 00000011 FFFFFFF8 00000000 02 00 101
B 01800802 00000000 00000011 00000011 0C 02 000
B 01A10003 00000011 00000000 00000000 0D 03 000
1 00000001 CAFEF00D 00000000 00000000 00 00 000
B 00811005 CAFEF00D 00000022 00000022 04 05 000
